/* verilog/sram_defs.svh */
// SRAM controller defines: address and data widths plus the read and write phase timings.
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// Word address width for the 256K x 16 device.
`define SRAM_ADDR_W 18

// Data bus width, two byte lanes.
`define SRAM_DATA_W 16

// Cycles between driving the address with OE low and sampling the read data.
// At 25 MHz three cycles leave ample margin over a 10 ns part.
`define SRAM_READ_WAIT 3

// Cycles that WE stays low during a write.
`define SRAM_WRITE_PULSE 4

// Idle cycles after WE rises before ready is reported.
`define SRAM_WRITE_RECOVER 2

`endif

/* verilog/sram_pkg.sv */
// SRAM package: the data word type shared by the byte-access stage and the bus port.
`include "sram_defs.svh"

package sram_pkg;

	// One SRAM data word.
	// The same bits are read either as a whole halfword or as a pair of byte
	// lanes. Lane 0 is the low byte and is strobed by LB, lane 1 is the high
	// byte and is strobed by UB.
	typedef union packed {
		logic [`SRAM_DATA_W-1:0]            half;
		logic [`SRAM_DATA_W/8-1:0][7:0]     lane;
	} sram_word_u;

endpackage

/* verilog/sram_bus_port.sv */
// SRAM bus port: timed CE, OE and WE sequencing for one word access with tristate data drive.
`timescale 1ns/1ps
`include "sram_defs.svh"

module sram_bus_port (
	input  logic                       i_clock,
	input  logic                       i_rst_n,
	input  logic                       i_enable,
	input  logic                       i_rw,
	input  logic [`SRAM_ADDR_W-1:0]    i_address,
	input  sram_pkg::sram_word_u       i_wdata,
	input  logic [1:0]                 i_lane_en,
	output sram_pkg::sram_word_u       o_rdata,
	output logic                       o_ready,
	output logic [`SRAM_ADDR_W-1:0]    o_sram_a,
	inout  wire  [`SRAM_DATA_W-1:0]    io_sram_d,
	output logic                       o_sram_ce_n,
	output logic                       o_sram_oe_n,
	output logic                       o_sram_we_n,
	output logic                       o_sram_lb_n,
	output logic                       o_sram_ub_n
);

	// The write ends the longest, so it sets the counter width.
	localparam int PHASE_LAST = `SRAM_WRITE_PULSE + `SRAM_WRITE_RECOVER + 1;
	localparam int PHASE_W = $clog2(PHASE_LAST + 1);

	localparam logic [PHASE_W-1:0] PH_IDLE = '0;
	localparam logic [PHASE_W-1:0] PH_READ_DONE = PHASE_W'(`SRAM_READ_WAIT + 1);
	localparam logic [PHASE_W-1:0] PH_WRITE_END = PHASE_W'(`SRAM_WRITE_PULSE);
	localparam logic [PHASE_W-1:0] PH_WRITE_DONE = PHASE_W'(PHASE_LAST);

	logic [PHASE_W-1:0] phase_q;
	logic               drive_q;
	logic               active;
	logic               start;
	logic               read_done;
	logic               write_end;
	logic               write_done;

	// An access is in flight while the host holds enable and ready is not yet up.
	assign active     = i_enable && !o_ready;
	assign start      = active && (phase_q == PH_IDLE);
	assign read_done  = active && !i_rw && (phase_q == PH_READ_DONE);
	assign write_end  = active && i_rw && (phase_q == PH_WRITE_END);
	assign write_done = active && i_rw && (phase_q == PH_WRITE_DONE);

	// The data bus is only driven while WE is low.
	assign io_sram_d = drive_q ? i_wdata.half : {`SRAM_DATA_W{1'bz}};

	// Phase sequencer and pin strobes.
	// Dropping enable at any point returns to idle, which also aborts an access.
	always_ff @(posedge i_clock) begin
		if (!i_rst_n || !i_enable) begin
			phase_q     <= PH_IDLE;
			o_ready     <= 1'b0;
			drive_q     <= 1'b0;
			o_sram_ce_n <= 1'b1;
			o_sram_oe_n <= 1'b1;
			o_sram_we_n <= 1'b1;
			o_sram_lb_n <= 1'b1;
			o_sram_ub_n <= 1'b1;
		end else if (start) begin
			phase_q     <= phase_q + 1'b1;
			o_sram_ce_n <= 1'b0;
			o_sram_oe_n <= i_rw;
			o_sram_we_n <= !i_rw;
			o_sram_lb_n <= !i_lane_en[0];
			o_sram_ub_n <= !i_lane_en[1];
			drive_q     <= i_rw;
		end else if (read_done || write_done) begin
			o_ready <= 1'b1;
		end else if (write_end) begin
			// End of the write pulse. The SRAM latches data on the rising WE.
			phase_q     <= phase_q + 1'b1;
			o_sram_ce_n <= 1'b1;
			o_sram_we_n <= 1'b1;
			o_sram_lb_n <= 1'b1;
			o_sram_ub_n <= 1'b1;
			drive_q     <= 1'b0;
		end else if (active) begin
			phase_q <= phase_q + 1'b1;
		end
	end

	// Address and read data registers.
	always_ff @(posedge i_clock) begin
		if (start) begin
			o_sram_a <= i_address;
		end
		if (read_done) begin
			o_rdata.half <= io_sram_d;
		end
	end

	// Output and write enables must never overlap on the pins.
	a_oe_we_exclusive: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(!o_sram_oe_n && !o_sram_we_n));

	// No bus contention: the SRAM drives the bus whenever OE is low.
	a_no_drive_during_read: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(drive_q && !o_sram_oe_n));

	// The host sees ready drop one cycle after it releases enable.
	a_ready_release: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$fell(i_enable) |=> !o_ready);

endmodule

/* verilog/sram_byte_access.sv */
// SRAM byte-access stage: maps byte and halfword requests onto word accesses with lane strobes.
`timescale 1ns/1ps
`include "sram_defs.svh"

module sram_byte_access (
	input  logic                       i_clock,
	input  logic                       i_rst_n,
	input  logic                       i_enable,
	input  logic                       i_rw,
	input  logic                       i_size_byte,
	input  logic                       i_signed,
	input  logic [`SRAM_ADDR_W:0]      i_address,
	input  logic [`SRAM_DATA_W-1:0]    i_wdata,
	input  sram_pkg::sram_word_u       i_port_rdata,
	output logic [`SRAM_ADDR_W-1:0]    o_port_address,
	output sram_pkg::sram_word_u       o_port_wdata,
	output logic [1:0]                 o_lane_en,
	output logic [`SRAM_DATA_W-1:0]    o_rdata
);

	import sram_pkg::*;

	localparam int BYTE_ADDR_W = `SRAM_ADDR_W + 1;

	logic              lane_sel;
	logic [7:0]        read_byte;
	logic              ext_bit;
	sram_word_u        write_word;

	// Bit 0 of the byte address picks the lane, the rest is the word address.
	assign lane_sel       = i_address[0];
	assign o_port_address = i_address[BYTE_ADDR_W-1:1];

	// A byte access strobes one lane only, a halfword access strobes both.
	always_comb begin
		if (i_size_byte) begin
			o_lane_en = lane_sel ? 2'b10 : 2'b01;
		end else begin
			o_lane_en = 2'b11;
		end
	end

	// Write data steering.
	// For a byte write the low byte is copied into both lanes, so whichever
	// lane is strobed receives it.
	always_comb begin
		if (i_size_byte) begin
			write_word.lane[0] = i_wdata[7:0];
			write_word.lane[1] = i_wdata[7:0];
		end else begin
			write_word.half = i_wdata;
		end
	end

	// Reads present a quiet zero word, the bus port ignores it anyway.
	assign o_port_wdata = i_rw ? write_word : '0;

	// Read extraction and extension.
	assign read_byte = i_port_rdata.lane[lane_sel];
	assign ext_bit   = i_signed && read_byte[7];

	always_comb begin
		if (i_size_byte) begin
			o_rdata = {{(`SRAM_DATA_W-8){ext_bit}}, read_byte};
		end else begin
			o_rdata = i_port_rdata.half;
		end
	end

	// Halfword requests must be aligned; the host holds the address for the
	// whole access, so this is checked on every enabled cycle.
	a_halfword_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_enable && !i_size_byte) |-> !i_address[0]);

endmodule

/* verilog/sram_subsystem.sv */
// SRAM subsystem: byte-access stage in front of the timed bus port, wired to the SRAM pins.
`timescale 1ns/1ps
`include "sram_defs.svh"

module sram_subsystem (
	input  logic                       i_clock,
	input  logic                       i_rst_n,
	input  logic                       i_enable,
	input  logic                       i_rw,
	input  logic                       i_size_byte,
	input  logic                       i_signed,
	input  logic [`SRAM_ADDR_W:0]      i_address,
	input  logic [`SRAM_DATA_W-1:0]    i_wdata,
	output logic [`SRAM_DATA_W-1:0]    o_rdata,
	output logic                       o_ready,
	output logic [`SRAM_ADDR_W-1:0]    o_sram_a,
	inout  wire  [`SRAM_DATA_W-1:0]    io_sram_d,
	output logic                       o_sram_ce_n,
	output logic                       o_sram_oe_n,
	output logic                       o_sram_we_n,
	output logic                       o_sram_lb_n,
	output logic                       o_sram_ub_n
);

	import sram_pkg::*;

	logic [`SRAM_ADDR_W-1:0]  port_address;
	sram_word_u               port_wdata;
	sram_word_u               port_rdata;
	logic [1:0]               lane_en;

	// Enable and rw go straight to both blocks, so there is no added latency.
	sram_byte_access u_byte_access (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_enable       (i_enable),
		.i_rw           (i_rw),
		.i_size_byte    (i_size_byte),
		.i_signed       (i_signed),
		.i_address      (i_address),
		.i_wdata        (i_wdata),
		.i_port_rdata   (port_rdata),
		.o_port_address (port_address),
		.o_port_wdata   (port_wdata),
		.o_lane_en      (lane_en),
		.o_rdata        (o_rdata)
	);

	sram_bus_port u_bus_port (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_enable    (i_enable),
		.i_rw        (i_rw),
		.i_address   (port_address),
		.i_wdata     (port_wdata),
		.i_lane_en   (lane_en),
		.o_rdata     (port_rdata),
		.o_ready     (o_ready),
		.o_sram_a    (o_sram_a),
		.io_sram_d   (io_sram_d),
		.o_sram_ce_n (o_sram_ce_n),
		.o_sram_oe_n (o_sram_oe_n),
		.o_sram_we_n (o_sram_we_n),
		.o_sram_lb_n (o_sram_lb_n),
		.o_sram_ub_n (o_sram_ub_n)
	);

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset generator: 40 ns clock, reset held low for five cycles.
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_rst_n
);

	localparam time HALF_PERIOD = 20ns;

	initial begin
		o_clock = 1'b0;
		forever #(HALF_PERIOD) o_clock = ~o_clock;
	end

	// Reset is released on a rising edge, like any other driven input.
	initial begin
		o_rst_n = 1'b0;
		repeat (5) @(posedge o_clock);
		o_rst_n <= 1'b1;
	end

endmodule

/* test/sram_model.sv */
// Behavioral asynchronous SRAM: 256K x 16 with LB and UB byte lanes on a shared data bus.
`timescale 1ns/1ps
`include "sram_defs.svh"

module sram_model (
	input  logic [`SRAM_ADDR_W-1:0] i_a,
	inout  wire  [`SRAM_DATA_W-1:0] io_d,
	input  logic                    i_ce_n,
	input  logic                    i_oe_n,
	input  logic                    i_we_n,
	input  logic                    i_lb_n,
	input  logic                    i_ub_n
);

	import sram_pkg::*;

	sram_word_u              mem [0:(1<<`SRAM_ADDR_W)-1];
	logic [`SRAM_ADDR_W-1:0] wr_addr;
	sram_word_u              wr_data;
	logic [1:0]              wr_lanes;
	logic                    reading;

	initial begin
		for (int i = 0; i < (1 << `SRAM_ADDR_W); i++) begin
			mem[i] = '0;
		end
	end

	// Each lane drives the bus only while its strobe is low during a read.
	assign reading = !i_ce_n && !i_oe_n && i_we_n;
	assign io_d[7:0]  = (reading && !i_lb_n) ? mem[i_a].lane[0] : 8'hzz;
	assign io_d[15:8] = (reading && !i_ub_n) ? mem[i_a].lane[1] : 8'hzz;

	// The write is captured once the pins settle after WE falls and is
	// committed on the rising WE, as the real part latches it.
	always @(negedge i_we_n) begin
		#1;
		wr_addr  = i_a;
		wr_data  = io_d;
		wr_lanes = {!i_ub_n && !i_ce_n, !i_lb_n && !i_ce_n};
	end

	always @(posedge i_we_n) begin
		if (wr_lanes[0]) begin
			mem[wr_addr].lane[0] = wr_data.lane[0];
		end
		if (wr_lanes[1]) begin
			mem[wr_addr].lane[1] = wr_data.lane[1];
		end
		wr_lanes = 2'b00;
	end

endmodule

/* test/tb_sram_subsystem.sv */
// SRAM subsystem testbench: random byte and halfword traffic checked against a byte-level model.
`timescale 1ns/1ps
`include "sram_defs.svh"

module tb_sram_subsystem;

	localparam int  N_TRANS    = 560;
	localparam time TIMEOUT_NS = N_TRANS * 10 * 40 + 10000;

	logic                    clock;
	logic                    rst_n;
	logic                    enable;
	logic                    rw;
	logic                    size_byte;
	logic                    sgn;
	logic [`SRAM_ADDR_W:0]   address;
	logic [`SRAM_DATA_W-1:0] wdata;
	logic [`SRAM_DATA_W-1:0] rdata;
	logic                    ready;
	logic [`SRAM_ADDR_W-1:0] sram_a;
	wire  [`SRAM_DATA_W-1:0] sram_d;
	logic                    ce_n;
	logic                    oe_n;
	logic                    we_n;
	logic                    lb_n;
	logic                    ub_n;

	integer      seed = 32'h20d2;
	int          errors = 0;
	int          checks = 0;
	logic [7:0]  model [int];
	bit          skip_word [int];
	int          written [$];

	tb_clock_gen u_clock_gen (.o_clock(clock), .o_rst_n(rst_n));

	sram_model u_sram (
		.i_a(sram_a), .io_d(sram_d), .i_ce_n(ce_n), .i_oe_n(oe_n),
		.i_we_n(we_n), .i_lb_n(lb_n), .i_ub_n(ub_n)
	);

	sram_subsystem uut (
		.i_clock(clock), .i_rst_n(rst_n), .i_enable(enable), .i_rw(rw),
		.i_size_byte(size_byte), .i_signed(sgn), .i_address(address),
		.i_wdata(wdata), .o_rdata(rdata), .o_ready(ready), .o_sram_a(sram_a),
		.io_sram_d(sram_d), .o_sram_ce_n(ce_n), .o_sram_oe_n(oe_n),
		.o_sram_we_n(we_n), .o_sram_lb_n(lb_n), .o_sram_ub_n(ub_n)
	);

	// Bytes that were never written read as zero, like the SRAM after power up.
	function automatic logic [7:0] model_byte(input int a);
		return model.exists(a) ? model[a] : 8'h00;
	endfunction

	function automatic logic [`SRAM_ADDR_W:0] random_address(input bit aligned);
		logic [`SRAM_ADDR_W:0] a;
		a = $random(seed);
		if (aligned) a[0] = 1'b0;
		while (skip_word.exists(int'(a >> 1))) begin
			a = $random(seed);
			if (aligned) a[0] = 1'b0;
		end
		return a;
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// One complete access, with latency and release checks built in.
	task automatic access(input string name, input bit w, input bit sz_byte,
			input bit s, input logic [`SRAM_ADDR_W:0] a, input logic [15:0] d,
			output logic [15:0] result);
		int edges;
		edges = 0;
		@(posedge clock);
		enable <= 1'b1;
		rw <= w;
		size_byte <= sz_byte;
		sgn <= s;
		address <= a;
		wdata <= d;
		forever begin
			@(posedge clock);
			edges++;
			@(negedge clock);
			if (ready) break;
			if (edges >= 20) begin
				errors++;
				$display("%s: ready never came up after 20 cycles", name);
				break;
			end
		end
		result = rdata;
		check_value({name, " latency"}, w ? 16'd8 : 16'd5, 16'(edges));
		// The pins carry the word address, which is the byte address without bit 0.
		checks++;
		if (sram_a !== a[`SRAM_ADDR_W:1]) begin
			errors++;
			$display("[FAIL] %s address: expected %h, actual %h", name,
				a[`SRAM_ADDR_W:1], sram_a);
		end
		@(posedge clock);
		enable <= 1'b0;
		@(posedge clock);
		@(negedge clock);
		checks++;
		if (ready || !ce_n || !oe_n || !we_n || !lb_n || !ub_n) begin
			errors++;
			$display("%s: ready or a strobe still active after enable dropped", name);
		end
	endtask

	task automatic aborted_write(input logic [`SRAM_ADDR_W:0] a, input logic [15:0] d);
		@(posedge clock);
		enable <= 1'b1;
		rw <= 1'b1;
		size_byte <= 1'b0;
		address <= a;
		wdata <= d;
		repeat (2) @(posedge clock);
		enable <= 1'b0;
		@(posedge clock);
		@(negedge clock);
		skip_word[int'(a >> 1)] = 1'b1;
		model.delete(int'(a));
		model.delete(int'(a) + 1);
	endtask

	initial begin
		logic [`SRAM_ADDR_W:0] a;
		logic [15:0]           d;
		logic [15:0]           r;
		logic [15:0]           exp;
		logic [7:0]            b;
		bit                    s;
		enable = 1'b0;
		rw = 1'b0;
		size_byte = 1'b0;
		sgn = 1'b0;
		address = '0;
		wdata = '0;
		@(posedge rst_n);
		repeat (2) @(posedge clock);

		// Halfword round trip.
		for (int i = 0; i < 200; i++) begin
			a = random_address(1'b1);
			d = $random(seed);
			access("halfword write", 1'b1, 1'b0, 1'b0, a, d, r);
			model[int'(a)] = d[7:0];
			model[int'(a) + 1] = d[15:8];
			written.push_back(int'(a));
			access("halfword read", 1'b0, 1'b0, 1'b0, a, '0, r);
			check_value("halfword read", {model_byte(a + 1), model_byte(a)}, r);
		end

		// Byte writes touch one lane, seen through a halfword read.
		for (int i = 0; i < 50; i++) begin
			a = written[$unsigned($random(seed)) % written.size()] | ($random(seed) & 1);
			d = $random(seed);
			access("byte write", 1'b1, 1'b1, 1'b0, a, d, r);
			model[int'(a)] = d[7:0];
			a[0] = 1'b0;
			access("lane read", 1'b0, 1'b0, 1'b0, a, '0, r);
			check_value("lane read", {model_byte(a + 1), model_byte(a)}, r);
		end

		// Byte reads with zero and sign extension.
		for (int i = 0; i < 50; i++) begin
			a = written[$unsigned($random(seed)) % written.size()] | ($random(seed) & 1);
			s = $random(seed);
			access("byte read", 1'b0, 1'b1, s, a, '0, r);
			b = model_byte(a);
			exp = s ? {{8{b[7]}}, b} : {8'h00, b};
			check_value("byte read", exp, r);
		end

		// Aborted writes, each followed by a normal round trip.
		for (int i = 0; i < 5; i++) begin
			aborted_write(random_address(1'b1), $random(seed));
			a = random_address(1'b1);
			d = $random(seed);
			access("post-abort write", 1'b1, 1'b0, 1'b0, a, d, r);
			model[int'(a)] = d[7:0];
			model[int'(a) + 1] = d[15:8];
			access("post-abort read", 1'b0, 1'b0, 1'b0, a, '0, r);
			check_value("post-abort read", {model_byte(a + 1), model_byte(a)}, r);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Watchdog sized from the transaction count at ten cycles each.
	initial begin
		#(TIMEOUT_NS * 1ns);
		$display("Timeout: the tests did not finish in the expected time.");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* sources.f */
+incdir+verilog
verilog/sram_pkg.sv
verilog/sram_bus_port.sv
verilog/sram_byte_access.sv
verilog/sram_subsystem.sv
test/tb_clock_gen.sv
test/sram_model.sv
test/tb_sram_subsystem.sv

/* Bender.yml */
package:
  name: sram_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sram_pkg.sv
      - verilog/sram_bus_port.sv
      - verilog/sram_byte_access.sv
      - verilog/sram_subsystem.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock_gen.sv
      - test/sram_model.sv
      - test/tb_sram_subsystem.sv
